// File: cpu_settings.svh
`ifndef CPU_SETTINGS_SVH
`define CPU_SETTINGS_SVH

// Data path word width
`define CPU_DATA_W 32

// General purpose register file
`define CPU_REG_CNT 32
`define CPU_REG_AW  5

`endif

// File: cpu_pkg.sv
`include "cpu_settings.svh"

package cpu_pkg;

typedef logic [`CPU_DATA_W-1:0] uint32_t;

// Operations handled by the execute slice
typedef enum logic [5:0] {
	OP_LUI,
	OP_ORI,
	OP_ADDIU,
	OP_AND,
	OP_OR,
	OP_XOR,
	OP_NOR,
	OP_ADD,
	OP_ADDU,
	OP_SUB,
	OP_SUBU,
	OP_CLZ,
	OP_CLO,
	OP_MOVZ,
	OP_MOVN,
	OP_JAL,
	OP_JALR,
	OP_SLL,
	OP_SLLV,
	OP_SRL,
	OP_SRLV,
	OP_SRA,
	OP_SRAV,
	OP_SLT,
	OP_SLTU,
	OP_INVALID
} op_t;

// Register format view
typedef struct packed {
	logic [5:0]            opcode;
	logic [`CPU_REG_AW-1:0] rs;
	logic [`CPU_REG_AW-1:0] rt;
	logic [`CPU_REG_AW-1:0] rd;
	logic [4:0]            shamt;
	logic [5:0]            funct;
} r_fields_t;

// Immediate format view
typedef struct packed {
	logic [5:0]            opcode;
	logic [`CPU_REG_AW-1:0] rs;
	logic [`CPU_REG_AW-1:0] rt;
	logic [15:0]           imm16;
} i_fields_t;

typedef union packed {
	r_fields_t r;
	i_fields_t i;
} instr_word_u;

typedef struct packed {
	op_t                   op;
	logic [`CPU_REG_AW-1:0] rs;
	logic [`CPU_REG_AW-1:0] rt;
	logic [`CPU_REG_AW-1:0] rd;  // Final destination, rt or r31 already resolved
} decoded_t;

// Decode register contents
typedef struct packed {
	uint32_t     pc;
	instr_word_u instr;
	decoded_t    decoded;
	uint32_t     reg1;
	uint32_t     reg2;
} pipeline_decode_t;

// Execute result headed for writeback
typedef struct packed {
	decoded_t              decoded;
	logic [`CPU_REG_AW-1:0] rd;  // Zero when nothing is written
	uint32_t               result;
} pipeline_exec_t;

endpackage

// File: count_bit.sv
`timescale 1ns/100ps

module count_bit (
	input  logic             bit_val,
	input  cpu_pkg::uint32_t val,
	output cpu_pkg::uint32_t count
);

logic run;  // Still inside the leading run

// Walk from the MSB down and stop counting at the first mismatch
always_comb begin
	run   = 1'b1;
	count = '0;
	for (int i = 31; i >= 0; i--) begin
		run   = run & (val[i] == bit_val);
		count = count + {31'b0, run};
	end
end

endmodule

// File: reg_file.sv
`timescale 1ns/100ps
`include "cpu_settings.svh"

module reg_file (
	input  logic                   clk,
	input  logic                   rst,
	input  logic [`CPU_REG_AW-1:0] raddr1,
	input  logic [`CPU_REG_AW-1:0] raddr2,
	output cpu_pkg::uint32_t       rdata1,
	output cpu_pkg::uint32_t       rdata2,
	input  logic                   we,
	input  logic [`CPU_REG_AW-1:0] waddr,
	input  cpu_pkg::uint32_t       wdata
);

import cpu_pkg::*;

uint32_t regs [`CPU_REG_CNT];

always_ff @(posedge clk) begin
	if (rst) begin
		for (int i = 0; i < `CPU_REG_CNT; i++)
			regs[i] <= '0;
	end else if (we) begin
		regs[waddr] <= wdata;
	end
end

// r0 is hardwired
assign rdata1 = (raddr1 == '0) ? '0 : regs[raddr1];
assign rdata2 = (raddr2 == '0) ? '0 : regs[raddr2];

// Writeback control must filter out destination r0
a_no_r0_write: assert property (
	@(posedge clk) disable iff (rst) we |-> waddr != '0
) else $error("register file write to r0");

endmodule

// File: instr_decode.sv
`timescale 1ns/100ps
`include "cpu_settings.svh"

module instr_decode (
	input  logic                      clk,
	input  logic                      rst,
	input  logic                      dec_load,
	input  cpu_pkg::uint32_t          instr,
	input  cpu_pkg::uint32_t          pc,
	input  cpu_pkg::uint32_t          op1,
	input  cpu_pkg::uint32_t          op2,
	output logic [`CPU_REG_AW-1:0]    rs,
	output logic [`CPU_REG_AW-1:0]    rt,
	output cpu_pkg::pipeline_decode_t dec_out
);

import cpu_pkg::*;

// Primary opcodes
localparam logic [5:0] OPC_SPECIAL  = 6'h00;
localparam logic [5:0] OPC_JAL      = 6'h03;
localparam logic [5:0] OPC_ADDIU    = 6'h09;
localparam logic [5:0] OPC_ORI      = 6'h0d;
localparam logic [5:0] OPC_LUI      = 6'h0f;
localparam logic [5:0] OPC_SPECIAL2 = 6'h1c;

instr_word_u iw;
op_t         op;
decoded_t    dec;

assign iw = instr;
assign rs = iw.r.rs;  // Register file read ports
assign rt = iw.r.rt;

always_comb begin
	op = OP_INVALID;
	case (iw.r.opcode)
		OPC_SPECIAL: begin
			case (iw.r.funct)
				6'h00: op = OP_SLL;
				6'h02: op = OP_SRL;
				6'h03: op = OP_SRA;
				6'h04: op = OP_SLLV;
				6'h06: op = OP_SRLV;
				6'h07: op = OP_SRAV;
				6'h09: op = OP_JALR;
				6'h0a: op = OP_MOVZ;
				6'h0b: op = OP_MOVN;
				6'h20: op = OP_ADD;
				6'h21: op = OP_ADDU;
				6'h22: op = OP_SUB;
				6'h23: op = OP_SUBU;
				6'h24: op = OP_AND;
				6'h25: op = OP_OR;
				6'h26: op = OP_XOR;
				6'h27: op = OP_NOR;
				6'h2a: op = OP_SLT;
				6'h2b: op = OP_SLTU;
				default: op = OP_INVALID;
			endcase
		end
		OPC_SPECIAL2: begin
			if (iw.r.funct == 6'h20)
				op = OP_CLZ;
			else if (iw.r.funct == 6'h21)
				op = OP_CLO;
		end
		OPC_JAL:   op = OP_JAL;
		OPC_ADDIU: op = OP_ADDIU;
		OPC_ORI:   op = OP_ORI;
		OPC_LUI:   op = OP_LUI;
		default:   op = OP_INVALID;
	endcase
end

// Destination depends on the format
always_comb begin
	dec.op = op;
	dec.rs = iw.r.rs;
	dec.rt = iw.r.rt;
	case (op)
		OP_LUI, OP_ORI, OP_ADDIU: dec.rd = iw.i.rt;
		OP_JAL:                   dec.rd = '1;  // Link register r31
		OP_INVALID:               dec.rd = '0;
		default:                  dec.rd = iw.r.rd;
	endcase
end

always_ff @(posedge clk) begin
	if (rst) begin
		dec_out.decoded <= '{op: OP_INVALID, rs: '0, rt: '0, rd: '0};
	end else if (dec_load) begin
		dec_out.pc      <= pc;
		dec_out.instr   <= iw;
		dec_out.decoded <= dec;
		dec_out.reg1    <= op1;  // Operands already forwarded
		dec_out.reg2    <= op2;
	end
end

endmodule

// File: instr_exec.sv
`timescale 1ns/100ps

module instr_exec (
	input  logic                      dec_valid,
	input  cpu_pkg::pipeline_decode_t data,
	output cpu_pkg::pipeline_exec_t   result
);

import cpu_pkg::*;

uint32_t exec_ret;
uint32_t reg1;
uint32_t reg2;
uint32_t imm_zext;
uint32_t imm_sext;
logic [4:0] shamt;

assign reg1 = data.reg1;
assign reg2 = data.reg2;
assign shamt = data.instr.r.shamt;

assign imm_zext = {16'b0, data.instr.i.imm16};
assign imm_sext = {{16{data.instr.i.imm16[15]}}, data.instr.i.imm16};

// Shared adder results
uint32_t add_u;
uint32_t sub_u;
assign add_u = reg1 + reg2;
assign sub_u = reg1 - reg2;

// Signed order follows the sign bits when they differ
logic signed_lt;
logic unsigned_lt;
assign signed_lt   = (reg1[31] != reg2[31]) ? reg1[31] : sub_u[31];
assign unsigned_lt = reg1 < reg2;

uint32_t clz_cnt;
uint32_t clo_cnt;

count_bit u_count_clz (
	.bit_val (1'b0),
	.val     (reg1),
	.count   (clz_cnt)
);

count_bit u_count_clo (
	.bit_val (1'b1),
	.val     (reg1),
	.count   (clo_cnt)
);

assign result.result = exec_ret;

always_comb begin
	result.decoded = data.decoded;
	result.rd      = data.decoded.rd;
	if (!dec_valid)
		result.rd = '0;  // Bubble
	else if ((data.decoded.op == OP_MOVZ && reg2 != '0)
		|| (data.decoded.op == OP_MOVN && reg2 == '0))
		result.rd = '0;  // Move condition false
end

always_comb begin
	exec_ret = '0;
	unique case (data.decoded.op)
		OP_LUI:            exec_ret = {data.instr.i.imm16, 16'b0};
		OP_ORI:            exec_ret = reg1 | imm_zext;
		OP_ADDIU:          exec_ret = reg1 + imm_sext;
		OP_AND:            exec_ret = reg1 & reg2;
		OP_OR:             exec_ret = reg1 | reg2;
		OP_XOR:            exec_ret = reg1 ^ reg2;
		OP_NOR:            exec_ret = ~(reg1 | reg2);
		OP_ADD, OP_ADDU:   exec_ret = add_u;  // No overflow trap
		OP_SUB, OP_SUBU:   exec_ret = sub_u;
		OP_CLZ:            exec_ret = clz_cnt;
		OP_CLO:            exec_ret = clo_cnt;
		OP_MOVZ, OP_MOVN:  exec_ret = reg1;
		OP_JAL, OP_JALR:   exec_ret = data.pc + 32'd8;  // Return past the delay slot
		OP_SLL:            exec_ret = reg2 << shamt;
		OP_SLLV:           exec_ret = reg2 << reg1[4:0];
		OP_SRL:            exec_ret = reg2 >> shamt;
		OP_SRLV:           exec_ret = reg2 >> reg1[4:0];
		OP_SRA:            exec_ret = $signed(reg2) >>> shamt;
		OP_SRAV:           exec_ret = $signed(reg2) >>> reg1[4:0];
		OP_SLT:            exec_ret = {31'b0, signed_lt};
		OP_SLTU:           exec_ret = {31'b0, unsigned_lt};
		default:           exec_ret = '0;
	endcase
end

// Decode must leave unknown encodings without a destination
always_comb begin
	if (dec_valid && data.decoded.op == OP_INVALID)
		a_invalid_no_rd: assert (data.decoded.rd == '0)
			else $error("invalid op carries rd %0d", data.decoded.rd);
end

endmodule

// File: pipe_ctrl.sv
`timescale 1ns/100ps
`include "cpu_settings.svh"

module pipe_ctrl (
	input  logic                    clk,
	input  logic                    rst,
	input  logic                    instr_valid,
	input  logic                    flush,
	input  logic [`CPU_REG_AW-1:0]  rs,
	input  logic [`CPU_REG_AW-1:0]  rt,
	input  cpu_pkg::uint32_t        rf_rdata1,
	input  cpu_pkg::uint32_t        rf_rdata2,
	input  cpu_pkg::pipeline_exec_t exec_out,
	output cpu_pkg::uint32_t        op1,
	output cpu_pkg::uint32_t        op2,
	output logic                    dec_load,
	output logic                    dec_valid,
	output logic                    rf_we,
	output logic [`CPU_REG_AW-1:0]  rf_waddr,
	output cpu_pkg::uint32_t        rf_wdata,
	output logic                    wb_valid,
	output logic [`CPU_REG_AW-1:0]  wb_reg,
	output cpu_pkg::uint32_t        wb_data
);

import cpu_pkg::*;

pipeline_exec_t w_stage;  // Writeback register
logic           w_valid;

// Youngest producer wins: execute, then writeback, then register file
function automatic uint32_t fwd(input logic [`CPU_REG_AW-1:0] addr, input uint32_t rf_val);
	if (addr == '0)
		return rf_val;
	if (addr == exec_out.rd)
		return exec_out.result;  // rd is zero for bubbles
	if (w_valid && addr == w_stage.rd)
		return w_stage.result;
	return rf_val;
endfunction

always_comb begin
	op1 = fwd(rs, rf_rdata1);
	op2 = fwd(rt, rf_rdata2);
end

assign dec_load = instr_valid && !flush;

assign rf_we    = w_valid && !flush && w_stage.rd != '0;
assign rf_waddr = w_stage.rd;
assign rf_wdata = w_stage.result;

always_ff @(posedge clk) begin
	if (rst) begin
		dec_valid <= 1'b0;
		w_valid   <= 1'b0;
		wb_valid  <= 1'b0;
	end else begin
		dec_valid <= instr_valid && !flush;
		w_valid   <= dec_valid && !flush;
		wb_valid  <= w_valid && !flush;
	end
end

always_ff @(posedge clk) begin
	w_stage <= exec_out;
	wb_reg  <= w_stage.rd;
	wb_data <= w_stage.result;
end

a_flush_clears: assert property (
	@(posedge clk) disable iff (rst) flush |=> !dec_valid && !w_valid && !wb_valid
) else $error("stage still valid after flush");

a_reset_quiet: assert property (
	@(posedge clk) rst |=> !wb_valid
) else $error("wb_valid high after reset");

endmodule

// File: exec_core.sv
`timescale 1ns/100ps
`include "cpu_settings.svh"

module exec_core (
	input  logic                   clk,
	input  logic                   rst,
	input  logic                   instr_valid,
	input  cpu_pkg::uint32_t       instr,
	input  cpu_pkg::uint32_t       pc,
	input  logic                   flush,
	output logic                   wb_valid,
	output logic [`CPU_REG_AW-1:0] wb_reg,
	output cpu_pkg::uint32_t       wb_data
);

import cpu_pkg::*;

logic [`CPU_REG_AW-1:0] rs;
logic [`CPU_REG_AW-1:0] rt;
logic [`CPU_REG_AW-1:0] rf_waddr;
uint32_t                rf_rdata1;
uint32_t                rf_rdata2;
uint32_t                rf_wdata;
uint32_t                op1;
uint32_t                op2;
logic                   rf_we;
logic                   dec_load;
logic                   dec_valid;
pipeline_decode_t       dec_out;
pipeline_exec_t         exec_out;

pipe_ctrl u_pipe_ctrl (
	.clk         (clk),
	.rst         (rst),
	.instr_valid (instr_valid),
	.flush       (flush),
	.rs          (rs),
	.rt          (rt),
	.rf_rdata1   (rf_rdata1),
	.rf_rdata2   (rf_rdata2),
	.exec_out    (exec_out),
	.op1         (op1),
	.op2         (op2),
	.dec_load    (dec_load),
	.dec_valid   (dec_valid),
	.rf_we       (rf_we),
	.rf_waddr    (rf_waddr),
	.rf_wdata    (rf_wdata),
	.wb_valid    (wb_valid),
	.wb_reg      (wb_reg),
	.wb_data     (wb_data)
);

instr_decode u_instr_decode (
	.clk      (clk),
	.rst      (rst),
	.dec_load (dec_load),
	.instr    (instr),
	.pc       (pc),
	.op1      (op1),
	.op2      (op2),
	.rs       (rs),
	.rt       (rt),
	.dec_out  (dec_out)
);

reg_file u_reg_file (
	.clk    (clk),
	.rst    (rst),
	.raddr1 (rs),
	.raddr2 (rt),
	.rdata1 (rf_rdata1),
	.rdata2 (rf_rdata2),
	.we     (rf_we),
	.waddr  (rf_waddr),
	.wdata  (rf_wdata)
);

instr_exec u_instr_exec (
	.dec_valid (dec_valid),
	.data      (dec_out),
	.result    (exec_out)
);

endmodule

// File: exec_core_tb.sv
`timescale 1ns/100ps
`include "cpu_settings.svh"

module exec_core_tb;

import cpu_pkg::*;

localparam int RAND_CNT = 40;

// One row holds what is offered and what writeback must show three edges later
typedef struct packed {
	logic [2:0]             test;
	uint32_t                instr;
	uint32_t                pc;
	logic                   flush;
	logic                   valid;
	logic [`CPU_REG_AW-1:0] rd;
	uint32_t                data;
} vec_t;

logic                   clk;
logic                   rst;
logic                   instr_valid;
uint32_t                instr;
uint32_t                pc;
logic                   flush;
logic                   wb_valid;
logic [`CPU_REG_AW-1:0] wb_reg;
uint32_t                wb_data;

vec_t tbl [$];
logic tbl_ready = 1'b0;
int   checks    = 0;
int   errors    = 0;
int   test_errs = 0;

exec_core uut (
	.clk         (clk),
	.rst         (rst),
	.instr_valid (instr_valid),
	.instr       (instr),
	.pc          (pc),
	.flush       (flush),
	.wb_valid    (wb_valid),
	.wb_reg      (wb_reg),
	.wb_data     (wb_data)
);

function automatic uint32_t enc_r(input int unsigned opc, input int unsigned rs,
	input int unsigned rt, input int unsigned rd, input int unsigned sh,
	input int unsigned funct);
	return {6'(opc), 5'(rs), 5'(rt), 5'(rd), 5'(sh), 6'(funct)};
endfunction

function automatic uint32_t enc_i(input int unsigned opc, input int unsigned rs,
	input int unsigned rt, input int unsigned imm);
	return {6'(opc), 5'(rs), 5'(rt), 16'(imm)};
endfunction

// Each row gets its own word address
function automatic uint32_t cur_pc();
	return 32'h0000_0400 + 32'(4 * tbl.size());
endfunction

function automatic void add_entry(input int unsigned test, input uint32_t iw,
	input int unsigned fl, input int unsigned valid, input int unsigned rd,
	input uint32_t data);
	vec_t v;
	v.test  = test[2:0];
	v.instr = iw;
	v.pc    = cur_pc();
	v.flush = fl[0];
	v.valid = valid[0];
	v.rd    = rd[`CPU_REG_AW-1:0];
	v.data  = data;
	tbl.push_back(v);
endfunction

// Random ADDIU and XOR chain on r10..r13 checked against a local register model
function automatic void add_random();
	uint32_t     model [4];
	logic [1:0]  d;
	logic [1:0]  s;
	logic [1:0]  t;
	logic [15:0] imm;
	uint32_t     val;
	for (int i = 0; i < RAND_CNT; i++) begin
		d   = (i < 4) ? 2'(i) : 2'($urandom_range(3));
		s   = 2'($urandom_range(3));
		t   = 2'($urandom_range(3));
		imm = 16'($urandom);
		if (i < 4) begin  // Seed all four from r0
			val = {{16{imm[15]}}, imm};
			add_entry(5, enc_i('h09, 0, 10 + 32'(d), 32'(imm)), 0, 1, 10 + 32'(d), val);
		end else if ($urandom_range(1) == 0) begin
			val = model[s] + {{16{imm[15]}}, imm};
			add_entry(5, enc_i('h09, 10 + 32'(s), 10 + 32'(d), 32'(imm)),
				0, 1, 10 + 32'(d), val);
		end else begin
			val = model[s] ^ model[t];
			add_entry(5, enc_r(0, 10 + 32'(s), 10 + 32'(t), 10 + 32'(d), 0, 'h26),
				0, 1, 10 + 32'(d), val);
		end
		model[d] = val;
	end
endfunction

function automatic void build_table();
	uint32_t jal_pc;
	add_entry(1, enc_i('h0f, 0, 1, 'h1234), 0, 1, 1, 32'h1234_0000);  // lui r1
	add_entry(1, enc_i('h0d, 1, 1, 'h5678), 0, 1, 1, 32'h1234_5678);  // ori on itself
	add_entry(1, enc_i('h0f, 0, 2, 'hff00), 0, 1, 2, 32'hff00_0000);
	add_entry(1, enc_i('h0d, 2, 2, 'h0ff0), 0, 1, 2, 32'hff00_0ff0);
	add_entry(1, enc_r(0, 1, 2, 3, 0, 'h24), 0, 1, 3, 32'h1200_0670);  // and
	add_entry(1, enc_r(0, 1, 2, 4, 0, 'h25), 0, 1, 4, 32'hff34_5ff8);  // or
	add_entry(1, enc_r(0, 3, 4, 5, 0, 'h26), 0, 1, 5, 32'hed34_5988);  // xor with both forwarded
	add_entry(1, enc_r(0, 5, 0, 6, 0, 'h27), 0, 1, 6, 32'h12cb_a677);  // nor
	add_entry(2, enc_i('h09, 0, 7, 'hffff), 0, 1, 7, 32'hffff_ffff);  // addiu -1
	add_entry(2, enc_i('h09, 7, 8, 'h0002), 0, 1, 8, 32'h0000_0001);  // wraps around
	add_entry(2, enc_r(0, 7, 7, 9, 0, 'h20), 0, 1, 9, 32'hffff_fffe);  // add
	add_entry(2, enc_r(0, 8, 7, 10, 0, 'h22), 0, 1, 10, 32'h0000_0002);  // sub
	add_entry(2, enc_r(0, 8, 9, 11, 0, 'h23), 0, 1, 11, 32'h0000_0003);  // subu
	add_entry(2, enc_r(0, 1, 2, 16, 0, 'h21), 0, 1, 16, 32'h1134_6668);  // addu drops the carry
	add_entry(2, enc_r(0, 7, 8, 12, 0, 'h2a), 0, 1, 12, 1);  // slt -1 < 1
	add_entry(2, enc_r(0, 7, 8, 13, 0, 'h2b), 0, 1, 13, 0);  // sltu
	add_entry(2, enc_r(0, 8, 7, 14, 0, 'h2a), 0, 1, 14, 0);
	add_entry(2, enc_r(0, 8, 7, 15, 0, 'h2b), 0, 1, 15, 1);
	add_entry(3, enc_i('h09, 0, 17, 'h0024), 0, 1, 17, 32'h0000_0024);  // low bits give 4
	add_entry(3, enc_r(0, 0, 1, 18, 4, 'h00), 0, 1, 18, 32'h2345_6780);  // sll
	add_entry(3, enc_r(0, 0, 2, 19, 8, 'h02), 0, 1, 19, 32'h00ff_000f);  // srl
	add_entry(3, enc_r(0, 0, 2, 20, 8, 'h03), 0, 1, 20, 32'hffff_000f);  // sra
	add_entry(3, enc_r(0, 17, 2, 21, 0, 'h04), 0, 1, 21, 32'hf000_ff00);  // sllv
	add_entry(3, enc_r(0, 17, 2, 22, 0, 'h06), 0, 1, 22, 32'h0ff0_00ff);  // srlv
	add_entry(3, enc_r(0, 17, 2, 23, 0, 'h07), 0, 1, 23, 32'hfff0_00ff);  // srav
	add_entry(3, enc_r('h1c, 8, 0, 24, 0, 'h20), 0, 1, 24, 31);  // clz
	add_entry(3, enc_r('h1c, 0, 0, 25, 0, 'h20), 0, 1, 25, 32);
	add_entry(3, enc_r('h1c, 20, 0, 26, 0, 'h21), 0, 1, 26, 16);  // clo
	add_entry(3, enc_r('h1c, 7, 0, 27, 0, 'h21), 0, 1, 27, 32);
	add_entry(3, enc_r('h1c, 19, 0, 28, 0, 'h20), 0, 1, 28, 8);
	add_entry(4, enc_r(0, 1, 0, 29, 0, 'h0a), 0, 1, 29, 32'h1234_5678);  // movz taken
	add_entry(4, enc_r(0, 2, 8, 29, 0, 'h0a), 0, 1, 0, 0);  // movz not taken
	add_entry(4, enc_r(0, 2, 0, 29, 0, 'h0b), 0, 1, 0, 0);  // movn not taken
	add_entry(4, enc_r(0, 29, 0, 30, 0, 'h25), 0, 1, 30, 32'h1234_5678);  // r29 kept
	add_entry(4, enc_r(0, 2, 8, 29, 0, 'h0b), 0, 1, 29, 32'hff00_0ff0);  // movn taken
	jal_pc = cur_pc();
	add_entry(4, enc_i('h03, 0, 0, 'h0100), 0, 1, 31, jal_pc + 8);  // jal links r31
	add_entry(4, enc_r(0, 1, 0, 16, 0, 'h09), 0, 1, 16, cur_pc() + 8);  // jalr
	add_entry(4, enc_r(0, 31, 0, 15, 0, 'h25), 0, 1, 15, jal_pc + 8);
	add_random();
	add_entry(6, enc_i('h09, 0, 2, 'h0022), 0, 1, 2, 32'h0000_0022);
	add_entry(6, enc_i('h09, 0, 3, 'h0033), 0, 0, 0, 0);  // In writeback at flush
	add_entry(6, enc_i('h09, 0, 4, 'h0044), 0, 0, 0, 0);  // In decode at flush
	add_entry(6, enc_i('h09, 0, 5, 'h0055), 1, 0, 0, 0);  // Offered with flush
	add_entry(6, enc_r(0, 3, 2, 6, 0, 'h26), 0, 1, 6, 32'h1200_0652);
	add_entry(6, enc_r(0, 4, 5, 7, 0, 'h21), 0, 1, 7, 32'hec68_b980);
	add_entry(6, enc_i('h09, 0, 0, 'h0077), 0, 1, 0, 0);  // r0 targets
	add_entry(6, enc_r(0, 1, 2, 0, 0, 'h21), 0, 1, 0, 0);
	add_entry(6, enc_r(0, 0, 0, 8, 0, 'h25), 0, 1, 8, 0);
endfunction

task automatic check_entry(input int k);
	vec_t e;
	e = tbl[k];
	checks++;
	if (wb_valid !== e.valid) begin
		$display("mismatch at time %0t: wb_valid got %b expected %b", $time, wb_valid, e.valid);
		test_errs++;
	end else if (e.valid) begin
		if (wb_reg !== e.rd) begin
			$display("mismatch at time %0t: wb_reg got %0d expected %0d", $time, wb_reg, e.rd);
			test_errs++;
		end
		if (e.rd != '0 && wb_data !== e.data) begin  // Data only matters when written
			$display("mismatch at time %0t: wb_data got %h expected %h", $time, wb_data, e.data);
			test_errs++;
		end
	end
	if (k == tbl.size() - 1 || tbl[k + 1].test != e.test) begin
		$display("test %0d finished with %0d errors", e.test, test_errs);
		errors += test_errs;
		test_errs = 0;
	end
endtask

initial begin
	clk = 1'b0;
	forever #4 clk = ~clk;
end

// Table already holds the random stream, so its size covers both parts
initial begin
	wait (tbl_ready);
	#((tbl.size() + 20) * 8);
	$display("watchdog expired before all rows were checked");
	$display("tests failed");
	$finish;
end

initial begin
	rst         = 1'b1;
	instr_valid = 1'b0;
	instr       = '0;
	pc          = '0;
	flush       = 1'b0;
	void'($urandom(74));
	build_table();
	tbl_ready = 1'b1;
	repeat (5) @(posedge clk);
	#1;
	rst = 1'b0;
	if (wb_valid !== 1'b0) begin
		$display("mismatch at time %0t: wb_valid got %b expected 0", $time, wb_valid);
		errors++;
	end
	for (int k = 0; k < tbl.size() + 3; k++) begin
		@(posedge clk);
		#1;
		if (k >= 3)
			check_entry(k - 3);  // Row offered three edges ago
		if (k < tbl.size()) begin
			instr_valid = 1'b1;
			instr       = tbl[k].instr;
			pc          = tbl[k].pc;
			flush       = tbl[k].flush;
		end else begin
			instr_valid = 1'b0;
			flush       = 1'b0;
		end
	end
	$display("%0d checks, %0d errors", checks, errors);
	if (errors == 0)
		$display("all tests passed");
	else
		$display("tests failed");
	$finish;
end

endmodule

// File: all.f
+incdir+.
cpu_pkg.sv
count_bit.sv
reg_file.sv
instr_decode.sv
instr_exec.sv
pipe_ctrl.sv
exec_core.sv
exec_core_tb.sv

// File: run.sh
#!/bin/sh
# Compile and run the testbench with Verilator
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -f all.f --top-module exec_core_tb -o exec_core_sim
out=$(./obj_dir/exec_core_sim)
printf '%s\n' "$out"
printf '%s\n' "$out" | grep -qx "all tests passed"
